//--- Bender.yml
package:
  name: tile_array

sources:
  - files:
      - hw/tile_pkg.sv
      - hw/credit_fifo.sv
      - hw/noc_inject.sv
      - hw/compute_tile.sv
      - hw/result_collect.sv
      - hw/tile_array.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tile_array_tb.sv

//--- dv/tb_checks.svh
/*
 * Testbench checks
 * Compare tasks for results and counts, the common stop on
 * error and an xorshift generator for output credit returns
 */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Report failure and end the run
task automatic abort_run();
   $display("SOME TESTS FAILED");
   $fatal(1, "simulation stopped at the first error");
endtask

// Whole result, tile id included
task automatic check_result(input tile_result_t got, input tile_result_t exp);
   if (got !== exp) begin
      $display("FAIL %0t: tile %0d r3 %h count %0d, expected tile %0d r3 %h count %0d",
               $time, got.tile, got.r3, got.count, exp.tile, exp.r3, exp.count);
      abort_run();
   end
endtask

task automatic check_count(input string what, input int got, input int exp);
   if (got != exp) begin
      $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run();
   end
endtask

// 32-bit xorshift, shifts 13 17 5
function automatic logic [31:0] next_random(input logic [31:0] x);
   logic [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

`endif

//--- dv/tile_array_tb.sv
/*
 * Tile array testbench
 * Streams commands from a data file into the array under
 * input credits, returns output credits at random and checks
 * every result against the expected list of its tile
 */

`timescale 1ns/10ps

module tile_array_tb;

   import tile_pkg::*;

   localparam int NUM_TILES   = 4;
   localparam int INJ_DEPTH   = 2;
   localparam int TILE_DEPTH  = 4;
   localparam int RES_DEPTH   = 2;
   localparam int OUT_CREDITS = 2;
   localparam int WAIT_LIMIT  = 2000;

   logic         clk;
   logic         reset;
   logic         in_valid;
   tile_flit_t   in_flit;
   logic         in_credit;
   logic         out_valid;
   tile_result_t out_res;
   logic         out_credit;

   tile_flit_t   cmd_q[$];
   tile_result_t exp_q[$];
   int           num_expected;
   // Host side credit state
   int           host_cred;
   int           out_owed;
   int           out_granted;
   int           flits_sent;
   int           credits_seen;
   int           results_seen;
   logic [31:0]  rng;

   `include "tb_checks.svh"

   tile_array #(
      .NUM_TILES   (NUM_TILES),
      .INJ_DEPTH   (INJ_DEPTH),
      .TILE_DEPTH  (TILE_DEPTH),
      .RES_DEPTH   (RES_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) dut_i (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_flit    (in_flit),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_res    (out_res),
      .out_credit (out_credit)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Commands and expected results in stream order
   task automatic load_tests();
      int           fd;
      int           n;
      string        line;
      logic [31:0]  f0;
      logic [31:0]  f1;
      logic [31:0]  f2;
      logic [31:0]  f3;
      fd = $fopen("dv/tile_array_tests.txt", "r");
      if (fd == 0) begin
         $display("Could not open the test file dv/tile_array_tests.txt");
         abort_run();
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line[0] != "#") begin
            n = 0;
            if (line[0] == "C") begin
               n = $sscanf(line, "C %h %h %h %h", f0, f1, f2, f3) - 1;
               cmd_q.push_back('{tile: f0[TILE_ID_W-1:0], op: tile_op_e'(f1[1:0]),
                                 reg_sel: f2[1:0], data: f3});
            end else if (line[0] == "R") begin
               n = $sscanf(line, "R %h %h %h", f0, f1, f2);
               exp_q.push_back('{tile: f0[TILE_ID_W-1:0], r3: f1, count: f2[7:0]});
            end
            if (n != 3) begin
               $display("Malformed line in the test file: %s", line);
               abort_run();
            end
         end
      end
      $fclose(fd);
   endtask

   // Oldest open entry of the same tile keeps per-tile order
   task automatic match_result(input tile_result_t got);
      int idx;
      idx = -1;
      foreach (exp_q[i]) begin
         if (idx < 0 && exp_q[i].tile == got.tile)
            idx = i;
      end
      if (idx < 0) begin
         $display("FAIL %0t: result from tile %0d with none expected", $time, got.tile);
         abort_run();
      end else begin
         check_result(got, exp_q[idx]);
         exp_q.delete(idx);
      end
   endtask

   // One clock of host activity driven just after the edge
   task automatic drive_cycle();
      @(posedge clk);
      #2;
      in_valid   = 1'b0;
      out_credit = 1'b0;
      if (cmd_q.size() > 0 && host_cred > 0) begin
         in_valid = 1'b1;
         in_flit  = cmd_q.pop_front();
         host_cred--;
         flits_sent++;
      end
      // Held back credits go out about half the time
      rng = next_random(rng);
      if (out_owed > 0 && rng[3]) begin
         out_credit = 1'b1;
         out_owed--;
         out_granted++;
      end
   endtask

   // Sampled mid-cycle away from the edges
   always @(negedge clk) begin
      if (!reset) begin
         if (in_credit) begin
            credits_seen++;
            host_cred++;
            if (host_cred > INJ_DEPTH) begin
               $display("in_credit gave back more credits than the input buffer holds");
               abort_run();
            end
         end
         if (out_valid) begin
            if (out_granted == 0) begin
               $display("out_valid arrived while no output credit was outstanding");
               abort_run();
            end
            out_granted--;
            out_owed++;
            results_seen++;
            match_result(out_res);
         end
      end
   end

   initial begin
      int waited;
      reset        = 1'b1;
      in_valid     = 1'b0;
      in_flit      = '0;
      out_credit   = 1'b0;
      host_cred    = INJ_DEPTH;
      out_owed     = 0;
      out_granted  = OUT_CREDITS;
      flits_sent   = 0;
      credits_seen = 0;
      results_seen = 0;
      rng          = 32'd84359;
      load_tests();
      num_expected = exp_q.size();
      repeat (4) @(posedge clk);
      #2;
      reset = 1'b0;

      waited = 0;
      while (cmd_q.size() > 0) begin
         if (waited == WAIT_LIMIT) begin
            $display("Timeout: commands still waiting for input credits");
            abort_run();
         end
         drive_cycle();
         waited++;
      end

      waited = 0;
      while (results_seen < num_expected) begin
         if (waited == WAIT_LIMIT) begin
            $display("Timeout: only %0d of %0d results arrived", results_seen, num_expected);
            abort_run();
         end
         drive_cycle();
         waited++;
      end

      // Drain a while so a duplicate would still show up
      waited = 0;
      while (waited < 20) begin
         drive_cycle();
         waited++;
      end

      check_count("in_credit pulses", credits_seen, flits_sent);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

//--- dv/tile_array_tests.txt
# C tile op reg data : command, op 0 load 1 add 2 xor 3 exit, all fields hex
# R tile r3 count    : expected result in exit order of that tile, all fields hex
C 0 0 3 00000005
C 1 0 3 ffffffff
C 0 1 3 00000007
C 1 1 3 00000002
C 0 2 3 000000ff
C 2 2 3 a5a5a5a5
C 1 0 1 12345678
C 0 3 0 00000000
R 0 000000f3 03
C 1 3 0 00000000
R 1 00000001 03
C 2 3 0 00000000
R 2 a5a5a5a5 01
C 3 1 3 00000001
C 3 1 3 00000001
C 3 1 3 00000001
C 3 1 3 00000001
C 3 1 3 00000001
C 3 3 0 00000000
R 3 00000005 05
C 3 3 0 00000000
R 3 00000000 00
C 3 2 3 0000000f
C 3 1 3 00000001
C 3 3 0 00000000
R 3 00000010 02
C 0 1 3 00000010
C 0 3 0 00000000
R 0 00000010 01
C 1 3 0 00000000
R 1 00000000 00

//--- hw/compute_tile.sv
/*
 * Compute tile
 * Runs load, add and xor commands on four 32-bit registers.
 * On exit it sends tile id, register 3 and the command count
 * to the collector, then clears registers and count
 */

`timescale 1ns/10ps

module compute_tile #(
   parameter int TILE_ID    = 0,
   parameter int TILE_DEPTH = tile_pkg::TILE_DEPTH_DEF,
   parameter int RES_DEPTH  = tile_pkg::RES_DEPTH_DEF
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   link_valid,
   input  tile_pkg::tile_flit_t   link_flit,
   output logic                   link_credit,
   output logic                   res_valid,
   output tile_pkg::tile_result_t res,
   input  logic                   res_credit
);

   import tile_pkg::*;

   localparam int CNT_W = $clog2(RES_DEPTH + 1);

   tile_flit_t       cmd;
   logic             cmd_empty;
   logic             cmd_pop;
   logic             is_exit;
   logic             emit;
   logic [31:0]      regs [4];
   logic [7:0]       cmd_count;
   logic [CNT_W-1:0] res_cred;

   // Command buffer, each pop returns a credit to the injector
   credit_fifo #(
      .payload_t (tile_flit_t),
      .DEPTH     (TILE_DEPTH)
   ) cmd_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (link_valid),
      .push_data (link_flit),
      .pop       (cmd_pop),
      .pop_data  (cmd),
      .empty     (cmd_empty),
      .credit    (link_credit)
   );

   assign is_exit = (cmd.op == OP_EXIT);
   // Exit waits for room in the collector
   assign cmd_pop = !cmd_empty && (!is_exit || (res_cred != '0));
   assign emit    = cmd_pop && is_exit;

   // Register file, count and result credits
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int r = 0; r < 4; r++)
            regs[r] <= '0;
         cmd_count <= '0;
         res_valid <= 1'b0;
         res_cred  <= CNT_W'(RES_DEPTH);
      end else begin
         res_valid <= emit;
         res_cred  <= res_cred + CNT_W'(res_credit) - CNT_W'(emit);
         if (cmd_pop) begin
            case (cmd.op)
               OP_LOAD: regs[cmd.reg_sel] <= cmd.data;
               // Add wraps at 32 bits
               OP_ADD:  regs[cmd.reg_sel] <= regs[cmd.reg_sel] + cmd.data;
               OP_XOR:  regs[cmd.reg_sel] <= regs[cmd.reg_sel] ^ cmd.data;
               OP_EXIT: begin
                  for (int r = 0; r < 4; r++)
                     regs[r] <= '0;
               end
               default: ;
            endcase
            // Count wraps at 8 bits, exit restarts it
            if (is_exit)
               cmd_count <= '0;
            else
               cmd_count <= cmd_count + 1'b1;
         end
      end
   end

   // Result payload, sampled before the clear
   always_ff @(posedge clk) begin
      if (emit) begin
         res <= '{tile:  TILE_ID_W'(TILE_ID),
                  r3:    regs[3],
                  count: cmd_count};
      end
   end

endmodule

//--- hw/credit_fifo.sv
/*
 * Credit FIFO
 * Circular buffer for any payload type with show-ahead read.
 * Hands back one credit per popped entry so the sender
 * can track free space without a full flag
 */

`timescale 1ns/10ps

module credit_fifo #(
   parameter type payload_t = logic [31:0],
   parameter int  DEPTH     = 4
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t pop_data,
   output logic     empty,
   output logic     credit
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] used;
   logic             do_pop;

   // Pointer step, wraps at DEPTH so odd depths work too
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign empty    = (used == '0);
   // Pop on empty is ignored
   assign do_pop   = pop && !empty;
   assign credit   = do_pop;
   assign pop_data = mem[rd_ptr];

   // Storage, overrun is ruled out by the sender's credits
   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         used   <= '0;
      end else begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (do_pop)
            rd_ptr <= next_ptr(rd_ptr);
         used <= used + CNT_W'(push) - CNT_W'(do_pop);
      end
   end

endmodule

//--- hw/noc_inject.sv
/*
 * Flit injector
 * Buffers host command flits and fans them out to the tiles.
 * One credit counter per tile, head flit leaves only when its
 * tile has room, so a full tile blocks the flits behind it
 */

`timescale 1ns/10ps

module noc_inject #(
   parameter int NUM_TILES  = 4,
   parameter int INJ_DEPTH  = 2,
   parameter int TILE_DEPTH = 4
) (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 in_valid,
   input  tile_pkg::tile_flit_t                 in_flit,
   output logic                                 in_credit,
   output logic [NUM_TILES-1:0]                 link_valid,
   output tile_pkg::tile_flit_t [NUM_TILES-1:0] link_flit,
   input  logic [NUM_TILES-1:0]                 link_credit
);

   import tile_pkg::*;

   localparam int CNT_W = $clog2(TILE_DEPTH + 1);

   tile_flit_t           head;
   logic                 head_empty;
   logic                 head_pop;
   logic                 dest_known;
   logic [NUM_TILES-1:0] send;
   logic [CNT_W-1:0]     tile_cred [NUM_TILES];

   // Host input buffer, its pop credit goes straight back to the host
   credit_fifo #(
      .payload_t (tile_flit_t),
      .DEPTH     (INJ_DEPTH)
   ) in_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (in_valid),
      .push_data (in_flit),
      .pop       (head_pop),
      .pop_data  (head),
      .empty     (head_empty),
      .credit    (in_credit)
   );

   // Decode destination of the head flit
   always_comb begin
      dest_known = 1'b0;
      send       = '0;
      for (int t = 0; t < NUM_TILES; t++) begin
         if (head.tile == t) begin
            dest_known = 1'b1;
            send[t]    = !head_empty && (tile_cred[t] != '0);
         end
      end
   end

   // Flits for a tile that is not there get dropped, else they jam the queue
   assign head_pop = (|send) || (!head_empty && !dest_known);

   // Per-tile credits and link valid
   always_ff @(posedge clk) begin
      if (reset) begin
         link_valid <= '0;
         for (int t = 0; t < NUM_TILES; t++)
            tile_cred[t] <= CNT_W'(TILE_DEPTH);
      end else begin
         link_valid <= send;
         for (int t = 0; t < NUM_TILES; t++)
            tile_cred[t] <= tile_cred[t] + CNT_W'(link_credit[t]) - CNT_W'(send[t]);
      end
   end

   // Link payload
   always_ff @(posedge clk) begin
      for (int t = 0; t < NUM_TILES; t++) begin
         if (send[t])
            link_flit[t] <= head;
      end
   end

endmodule

//--- hw/result_collect.sv
/*
 * Result collector
 * One result buffer per tile, merged round-robin onto the
 * host output link. Sends only while it holds a host credit
 */

`timescale 1ns/10ps

module result_collect #(
   parameter int NUM_TILES   = 4,
   parameter int RES_DEPTH   = 2,
   parameter int OUT_CREDITS = 2
) (
   input  logic                                   clk,
   input  logic                                   reset,
   input  logic [NUM_TILES-1:0]                   res_valid,
   input  tile_pkg::tile_result_t [NUM_TILES-1:0] res,
   output logic [NUM_TILES-1:0]                   res_credit,
   output logic                                   out_valid,
   output tile_pkg::tile_result_t                 out_res,
   input  logic                                   out_credit
);

   import tile_pkg::*;

   localparam int IDX_W = (NUM_TILES > 1) ? $clog2(NUM_TILES) : 1;
   localparam int CNT_W = $clog2(OUT_CREDITS + 1);

   tile_result_t         head [NUM_TILES];
   logic [NUM_TILES-1:0] empty;
   logic [NUM_TILES-1:0] grant;
   logic [IDX_W-1:0]     last;
   logic [IDX_W-1:0]     pick;
   logic                 found;
   logic                 send;
   logic [CNT_W-1:0]     out_cred;

   // Per-tile buffers, credit back to the tile when a result leaves
   for (genvar t = 0; t < NUM_TILES; t++) begin : g_buf
      credit_fifo #(
         .payload_t (tile_result_t),
         .DEPTH     (RES_DEPTH)
      ) res_fifo (
         .clk       (clk),
         .reset     (reset),
         .push      (res_valid[t]),
         .push_data (res[t]),
         .pop       (grant[t]),
         .pop_data  (head[t]),
         .empty     (empty[t]),
         .credit    (res_credit[t])
      );
   end

   // Rotating priority, search starts just after the last winner
   always_comb begin
      int idx;
      found = 1'b0;
      pick  = last;
      for (int i = 1; i <= NUM_TILES; i++) begin
         idx = (int'(last) + i) % NUM_TILES;
         if (!found && !empty[idx]) begin
            found = 1'b1;
            pick  = IDX_W'(idx);
         end
      end
      send  = found && (out_cred != '0);
      grant = '0;
      if (send)
         grant[pick] = 1'b1;
   end

   // Arbiter state and host credits
   always_ff @(posedge clk) begin
      if (reset) begin
         // Tile 0 wins first
         last      <= IDX_W'(NUM_TILES - 1);
         out_valid <= 1'b0;
         out_cred  <= CNT_W'(OUT_CREDITS);
      end else begin
         out_valid <= send;
         out_cred  <= out_cred + CNT_W'(out_credit) - CNT_W'(send);
         if (send)
            last <= pick;
      end
   end

   // Output payload
   always_ff @(posedge clk) begin
      if (send)
         out_res <= head[pick];
   end

endmodule

//--- hw/tile_array.sv
/*
 * Tile array top level
 * Host flits enter through the injector, fan out to the
 * compute tiles and come back as results via the collector.
 * All links use credit flow control
 */

`timescale 1ns/10ps

module tile_array #(
   // At most tile_pkg::MAX_TILES
   parameter int NUM_TILES   = tile_pkg::NUM_TILES_DEF,
   parameter int INJ_DEPTH   = tile_pkg::INJ_DEPTH_DEF,
   parameter int TILE_DEPTH  = tile_pkg::TILE_DEPTH_DEF,
   parameter int RES_DEPTH   = tile_pkg::RES_DEPTH_DEF,
   parameter int OUT_CREDITS = 2
) (
   input  logic                   clk,
   input  logic                   reset,
   // Host input link
   input  logic                   in_valid,
   input  tile_pkg::tile_flit_t   in_flit,
   output logic                   in_credit,
   // Host output link
   output logic                   out_valid,
   output tile_pkg::tile_result_t out_res,
   input  logic                   out_credit
);

   import tile_pkg::*;

   logic [NUM_TILES-1:0]         link_valid;
   tile_flit_t [NUM_TILES-1:0]   link_flit;
   logic [NUM_TILES-1:0]         link_credit;
   logic [NUM_TILES-1:0]         res_valid;
   tile_result_t [NUM_TILES-1:0] res;
   logic [NUM_TILES-1:0]         res_credit;

   noc_inject #(
      .NUM_TILES  (NUM_TILES),
      .INJ_DEPTH  (INJ_DEPTH),
      .TILE_DEPTH (TILE_DEPTH)
   ) inject_i (
      .clk         (clk),
      .reset       (reset),
      .in_valid    (in_valid),
      .in_flit     (in_flit),
      .in_credit   (in_credit),
      .link_valid  (link_valid),
      .link_flit   (link_flit),
      .link_credit (link_credit)
   );

   // Identical tiles, id from the loop index
   for (genvar t = 0; t < NUM_TILES; t++) begin : g_tile
      compute_tile #(
         .TILE_ID    (t),
         .TILE_DEPTH (TILE_DEPTH),
         .RES_DEPTH  (RES_DEPTH)
      ) tile_i (
         .clk         (clk),
         .reset       (reset),
         .link_valid  (link_valid[t]),
         .link_flit   (link_flit[t]),
         .link_credit (link_credit[t]),
         .res_valid   (res_valid[t]),
         .res         (res[t]),
         .res_credit  (res_credit[t])
      );
   end

   result_collect #(
      .NUM_TILES   (NUM_TILES),
      .RES_DEPTH   (RES_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) collect_i (
      .clk        (clk),
      .reset      (reset),
      .res_valid  (res_valid),
      .res        (res),
      .res_credit (res_credit),
      .out_valid  (out_valid),
      .out_res    (out_res),
      .out_credit (out_credit)
   );

endmodule

//--- hw/tile_pkg.sv
/*
 * Tile array shared types
 * Command flit and result formats, the tile opcode set
 * and the default sizes used by the top level
 */

package tile_pkg;

   // Tile address space, a top level holds at most this many tiles
   localparam int MAX_TILES = 16;
   localparam int TILE_ID_W = $clog2(MAX_TILES);

   // Default array sizes
   localparam int NUM_TILES_DEF  = 4;
   localparam int TILE_DEPTH_DEF = 4;
   // Host input buffer, also the credits the host starts with
   localparam int INJ_DEPTH_DEF  = 2;
   localparam int RES_DEPTH_DEF  = 2;

   // Tile commands
   typedef enum logic [1:0] {
      OP_LOAD = 2'd0,
      OP_ADD  = 2'd1,
      OP_XOR  = 2'd2,
      OP_EXIT = 2'd3
   } tile_op_e;

   // Host to tile command, 40 bits
   typedef struct packed {
      logic [TILE_ID_W-1:0] tile;
      tile_op_e             op;
      logic [1:0]           reg_sel;
      logic [31:0]          data;
   } tile_flit_t;

   // Tile to host result, 44 bits
   typedef struct packed {
      logic [TILE_ID_W-1:0] tile;
      logic [31:0]          r3;
      // Non-exit commands since the last exit
      logic [7:0]           count;
   } tile_result_t;

endpackage

//--- sim.f
+incdir+dv
hw/tile_pkg.sv
hw/credit_fifo.sv
hw/noc_inject.sv
hw/compute_tile.sv
hw/result_collect.sv
hw/tile_array.sv
dv/tile_array_tb.sv
